// ==== hw/video_cfg.svh ====
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// visible image
`define IMG_W      128
`define IMG_H      128

// clocks per line, lines per frame (short blanking for simulation)
`define H_TOTAL    160
`define V_TOTAL    136

// horizontal sync window in clocks, inclusive
`define HS_START   132
`define HS_END     143

// vertical sync window in lines, inclusive
`define VS_START   130
`define VS_END     131

`endif

// ==== hw/video_pkg.sv ====
`include "video_cfg.svh"

package video_pkg;

   // line * IMG_W + column, one bit per plane at each address
   typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] pix_addr_t;

   // horizontal or vertical count
   typedef logic [$clog2(`H_TOTAL)-1:0] coord_t;

   // red in bit 2, green in bit 1, blue in bit 0
   typedef logic [2:0] rgb_t;

   typedef enum logic [1:0] {
      st_idle,   // counters held at 0, host owns the memories
      st_scan,   // scanning frames
      st_drain   // enable dropped, finishing the current frame
   } ctrl_state_t;

endpackage

// ==== hw/scan_timing.sv ====
`timescale 1ns/1ps
`include "video_cfg.svh"

module scan_timing
   import video_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   output pix_addr_t pix_addr,
   output logic      active,
   output logic      in_vblank,
   output logic      frame_end,
   output logic      raw_hsync,
   output logic      raw_vsync
);

   localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);
   localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);
   localparam coord_t H_VIS  = coord_t'(`IMG_W);
   localparam coord_t V_VIS  = coord_t'(`IMG_H);
   localparam coord_t HS_ON  = coord_t'(`HS_START);
   localparam coord_t HS_OFF = coord_t'(`HS_END);
   localparam coord_t VS_ON  = coord_t'(`VS_START);
   localparam coord_t VS_OFF = coord_t'(`VS_END);

   localparam int COL_BITS = $clog2(`IMG_W);
   localparam int ROW_BITS = $clog2(`IMG_H);

   coord_t h_cnt;        // clock within line
   coord_t v_cnt;        // line within frame
   logic   line_end;
   logic   last_line;

   assign line_end  = (h_cnt == H_LAST);
   assign last_line = (v_cnt == V_LAST);

   // counters sit at 0 whenever the controller is idle
   always_ff @(posedge clk) begin
      if (rst || !run) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (line_end) begin
         h_cnt <= '0;
         if (last_line) begin
            v_cnt <= '0;
         end else begin
            v_cnt <= v_cnt + coord_t'(1);
         end
      end else begin
         h_cnt <= h_cnt + coord_t'(1);
      end
   end

   // (0,0) is inside the image, so gate with run or idle would look visible
   assign active    = run && (h_cnt < H_VIS) && (v_cnt < V_VIS);
   assign in_vblank = (v_cnt >= V_VIS);
   assign frame_end = run && line_end && last_line;   // last clock of the frame

   assign raw_hsync = (h_cnt >= HS_ON) && (h_cnt <= HS_OFF);
   assign raw_vsync = (v_cnt >= VS_ON) && (v_cnt <= VS_OFF);

   // row and column packed, only meaningful while active
   assign pix_addr = {v_cnt[ROW_BITS-1:0], h_cnt[COL_BITS-1:0]};

endmodule

// ==== hw/color_plane_ram.sv ====
`timescale 1ns/1ps

module color_plane_ram
   import video_pkg::*;
(
   input  logic      clk,
   input  logic      we,
   input  logic      rd_en,
   input  pix_addr_t addr,
   input  logic      wdata,
   output logic      rdata
);

   localparam int DEPTH = 2 ** $bits(pix_addr_t);   // 16K entries

   // one bit per pixel, maps onto a single block RAM
   logic mem [DEPTH];

   // single port shared by host writes and scan reads
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
         rdata     <= wdata;      // write first
      end else if (rd_en) begin
         rdata <= mem[addr];
      end
   end

endmodule

// ==== hw/display_ctrl.sv ====
`timescale 1ns/1ps

module display_ctrl
   import video_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   input  logic      load_en,
   input  pix_addr_t load_addr,
   input  pix_addr_t pix_addr,
   input  logic      active,
   input  logic      in_vblank,
   input  logic      frame_end,
   output logic      run,
   output logic      load_ok,
   output logic      ram_we,
   output logic      ram_rd_en,
   output pix_addr_t ram_addr
);

   ctrl_state_t state;
   ctrl_state_t state_nxt;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (enable) begin
               state_nxt = st_scan;
            end
         end
         st_scan: begin
            if (!enable) begin
               state_nxt = frame_end ? st_idle : st_drain;   // stop right away on the last clock
            end
         end
         st_drain: begin
            if (enable) begin
               state_nxt = st_scan;      // counters never stopped
            end else if (frame_end) begin
               state_nxt = st_idle;
            end
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   assign run = (state != st_idle);

   // host may write only when no visible pixel can be read
   assign load_ok = (state == st_idle) || in_vblank;

   // port sharing, a host write takes the address for its cycle
   assign ram_we    = load_en && load_ok;
   assign ram_rd_en = active;
   assign ram_addr  = ram_we ? load_addr : pix_addr;

endmodule

// ==== hw/pixel_output.sv ====
`timescale 1ns/1ps
`include "video_cfg.svh"

module pixel_output
   import video_pkg::*;
(
   input  logic clk,
   input  logic rst,
   input  rgb_t plane_rgb,
   input  logic raw_hsync,
   input  logic raw_vsync,
   input  logic active,
   output logic hsync,
   output logic vsync,
   output logic de,
   output rgb_t rgb
);

   logic hsync_d1;   // aligned with the memory read
   logic vsync_d1;
   logic active_d1;

   always_ff @(posedge clk) begin
      if (rst) begin
         hsync_d1  <= 1'b0;
         vsync_d1  <= 1'b0;
         active_d1 <= 1'b0;
      end else begin
         hsync_d1  <= raw_hsync;
         vsync_d1  <= raw_vsync;
         active_d1 <= active;
      end
   end

   // output register, plane data arrives together with active_d1
   always_ff @(posedge clk) begin
      if (rst) begin
         hsync <= 1'b0;
         vsync <= 1'b0;
         de    <= 1'b0;
         rgb   <= '0;
      end else begin
         hsync <= hsync_d1;
         vsync <= vsync_d1;
         de    <= active_d1;
         rgb   <= active_d1 ? plane_rgb : '0;   // black outside the image
      end
   end

endmodule

// ==== hw/frame_display_top.sv ====
`timescale 1ns/1ps
`include "video_cfg.svh"

module frame_display_top
   import video_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      enable,
   input  logic      load_en,
   input  pix_addr_t load_addr,
   input  rgb_t      load_rgb,
   output logic      load_ok,
   output logic      hsync,
   output logic      vsync,
   output logic      de,
   output rgb_t      rgb
);

   logic      run;
   logic      active;
   logic      in_vblank;
   logic      frame_end;
   logic      raw_hsync;
   logic      raw_vsync;
   pix_addr_t pix_addr;
   pix_addr_t ram_addr;      // shared by all three planes
   logic      ram_we;
   logic      ram_rd_en;
   rgb_t      plane_rgb;

   display_ctrl display_ctrl_inst (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .load_en   (load_en),
      .load_addr (load_addr),
      .pix_addr  (pix_addr),
      .active    (active),
      .in_vblank (in_vblank),
      .frame_end (frame_end),
      .run       (run),
      .load_ok   (load_ok),
      .ram_we    (ram_we),
      .ram_rd_en (ram_rd_en),
      .ram_addr  (ram_addr)
   );

   scan_timing scan_timing_inst (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .pix_addr  (pix_addr),
      .active    (active),
      .in_vblank (in_vblank),
      .frame_end (frame_end),
      .raw_hsync (raw_hsync),
      .raw_vsync (raw_vsync)
   );

   color_plane_ram red_plane (
      .clk   (clk),
      .we    (ram_we),
      .rd_en (ram_rd_en),
      .addr  (ram_addr),
      .wdata (load_rgb[2]),
      .rdata (plane_rgb[2])
   );

   color_plane_ram green_plane (
      .clk   (clk),
      .we    (ram_we),
      .rd_en (ram_rd_en),
      .addr  (ram_addr),
      .wdata (load_rgb[1]),
      .rdata (plane_rgb[1])
   );

   color_plane_ram blue_plane (
      .clk   (clk),
      .we    (ram_we),
      .rd_en (ram_rd_en),
      .addr  (ram_addr),
      .wdata (load_rgb[0]),
      .rdata (plane_rgb[0])
   );

   pixel_output pixel_output_inst (
      .clk       (clk),
      .rst       (rst),
      .plane_rgb (plane_rgb),
      .raw_hsync (raw_hsync),
      .raw_vsync (raw_vsync),
      .active    (active),
      .hsync     (hsync),
      .vsync     (vsync),
      .de        (de),
      .rgb       (rgb)
   );

endmodule

// ==== bench/tb_frame_display.sv ====
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_frame_display
   import video_pkg::*;
();

   localparam int PIXELS        = `IMG_W * `IMG_H;
   localparam int FRAME_CYCLES  = `H_TOTAL * `V_TOTAL;
   localparam int FRAME_TIMEOUT = 2 * FRAME_CYCLES + 100;
   localparam int QUIET_CYCLES  = (`V_TOTAL - `IMG_H) * `H_TOTAL + 500;   // past a next frame start
   localparam int PIPE_DELAY    = 2;   // memory read plus output register
   localparam int SCAN_AT_VS_FALL = (`VS_END + 1) * `H_TOTAL + PIPE_DELAY;   // counters at vsync fall

   logic      clk = 1'b0;
   logic      rst;
   logic      enable;
   logic      load_en;
   pix_addr_t load_addr;
   rgb_t      load_rgb;
   logic      load_ok;
   logic      hsync;
   logic      vsync;
   logic      de;
   rgb_t      rgb;

   rgb_t        model [PIXELS];   // expected image
   logic [31:0] rng_state = 32'd26;
   logic        enable_req = 1'b0;  // level applied to enable at each rising edge
   int          checks = 0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          writes_taken = 0;
   int          writes_dropped = 0;

   frame_display_top frame_display_top_inst (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_rgb  (load_rgb),
      .load_ok   (load_ok),
      .hsync     (hsync),
      .vsync     (vsync),
      .de        (de),
      .rgb       (rgb)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      begin
         y = x ^ (x << 13);
         y = y ^ (y >> 17);
         y = y ^ (y << 5);
         return y;
      end
   endfunction

   // while scanning, host writes are legal only in the blanking lines
   function automatic bit load_window_open(input int cyc);
      int pos;
      begin
         pos = (SCAN_AT_VS_FALL + cyc) % FRAME_CYCLES;
         return (pos / `H_TOTAL) >= `IMG_H;
      end
   endfunction

   task automatic next_random(output logic [31:0] r);
      begin
         rng_state = xorshift32(rng_state);
         r = rng_state;
      end
   endtask

   task automatic check_value(input string name, input int expected, input int actual);
      begin
         checks++;
         if (expected != actual) begin
            errors++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, expected, actual);
         end
      end
   endtask

   task automatic note_failure(input string msg);
      begin
         errors++;
         $display("at %0t: %s", $time, msg);
      end
   endtask

   // drive on the rising edge, sample in the middle of the cycle
   task automatic drive_cycle(input logic we, input pix_addr_t a, input rgb_t c);
      begin
         @(posedge clk);
         enable    <= enable_req;
         load_en   <= we;
         load_addr <= a;
         load_rgb  <= c;
         @(negedge clk);
         if (load_en && load_ok) begin
            model[load_addr] = load_rgb;   // DUT takes it at the next edge
            writes_taken++;
         end else if (load_en) begin
            writes_dropped++;
         end
      end
   endtask

   task automatic step_cycle(input bit do_writes);
      logic [31:0] r;
      begin
         if (do_writes) begin
            next_random(r);
            drive_cycle(1'b1, r[13:0], r[16:14]);
         end else begin
            drive_cycle(1'b0, '0, '0);
         end
      end
   endtask

   task automatic check_pixel(inout int de_cnt);
      pix_addr_t a;
      begin
         if (de) begin
            a = pix_addr_t'(de_cnt);   // raster order, line * width + column
            check_value("rgb", int'(model[a]), int'(rgb));
            de_cnt++;
         end else begin
            check_value("rgb blanked", 0, int'(rgb));
         end
      end
   endtask

   task automatic wait_vsync_fall(input bit do_writes, output bit ok);
      int   cnt;
      logic prev_vs;
      begin
         ok = 1'b0;
         cnt = 0;
         prev_vs = vsync;
         while (!ok && cnt < FRAME_TIMEOUT) begin
            step_cycle(do_writes);
            ok = prev_vs && !vsync;
            prev_vs = vsync;
            cnt++;
         end
         if (!ok) begin
            note_failure("no vsync falling edge within two frame times");
         end
      end
   endtask

   // one frame from a vsync fall to the next, pixels and shape
   task automatic check_frame(input bit do_writes);
      int   cyc;
      int   de_cnt;
      int   run_len;
      int   runs;
      int   hs_rises;
      int   last_rise;
      int   vs_cycles;
      bit   ok;
      bit   done;
      logic prev_de;
      logic prev_hs;
      logic prev_vs;
      begin
         cyc = 0;
         de_cnt = 0;
         run_len = 0;
         runs = 0;
         hs_rises = 0;
         last_rise = 0;
         vs_cycles = 0;
         done = 1'b0;
         wait_vsync_fall(do_writes, ok);
         if (ok) begin
            prev_de = de;
            prev_hs = hsync;
            prev_vs = vsync;
            while (!done && cyc < FRAME_TIMEOUT) begin
               check_pixel(de_cnt);
               check_value("load_ok", int'(load_window_open(cyc)), int'(load_ok));
               if (de) begin
                  run_len++;
               end
               if (!de && prev_de) begin
                  check_value("de run length", `IMG_W, run_len);
                  runs++;
                  run_len = 0;
               end
               if (hsync && !prev_hs) begin
                  if (hs_rises > 0) begin
                     check_value("hsync period", `H_TOTAL, cyc - last_rise);
                  end
                  last_rise = cyc;
                  hs_rises++;
               end
               if (vsync) begin
                  vs_cycles++;
               end
               prev_de = de;
               prev_hs = hsync;
               prev_vs = vsync;
               step_cycle(do_writes);
               cyc++;
               done = prev_vs && !vsync;
            end
            if (!done) begin
               note_failure("frame did not end with a second vsync falling edge");
            end else begin
               check_value("de runs", `IMG_H, runs);
               check_value("hsync rises", `V_TOTAL, hs_rises);
               check_value("vsync high cycles", (`VS_END - `VS_START + 1) * `H_TOTAL, vs_cycles);
               check_value("de cycles", PIXELS, de_cnt);
            end
         end
      end
   endtask

   task automatic end_test(input string name, input int errs_at_start);
      begin
         tests_run++;
         if (errors == errs_at_start) begin
            $display("test %s: ok", name);
         end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_at_start);
         end
      end
   endtask

   initial begin
      int          e0;
      int          i;
      int          cnt;
      int          de_cnt;
      int          taken0;
      int          dropped0;
      bit          ok;
      logic [31:0] r;

      rst       <= 1'b1;
      enable    <= 1'b0;
      load_en   <= 1'b0;
      load_addr <= '0;
      load_rgb  <= '0;
      for (i = 0; i < PIXELS; i++) begin
         model[i] = '0;
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      e0 = errors;
      for (i = 0; i < 20; i++) begin
         step_cycle(1'b0);
         check_value("load_ok", 1, int'(load_ok));
         check_value("hsync", 0, int'(hsync));
         check_value("vsync", 0, int'(vsync));
         check_value("de", 0, int'(de));
         check_value("rgb", 0, int'(rgb));
      end
      end_test("reset state", e0);

      e0 = errors;
      taken0 = writes_taken;
      for (i = 0; i < PIXELS; i++) begin
         next_random(r);
         drive_cycle(1'b1, pix_addr_t'(i), r[2:0]);
      end
      check_value("writes accepted in idle", PIXELS, writes_taken - taken0);
      enable_req = 1'b1;
      check_frame(1'b0);
      end_test("full image load", e0);

      e0 = errors;
      check_frame(1'b0);
      end_test("frame shape", e0);

      e0 = errors;
      taken0 = writes_taken;
      dropped0 = writes_dropped;
      check_frame(1'b1);
      if (writes_taken == taken0) begin
         note_failure("no random write was accepted during vertical blanking");
      end
      if (writes_dropped == dropped0) begin
         note_failure("no random write was dropped during the visible area");
      end
      check_frame(1'b0);
      end_test("write lockout", e0);

      e0 = errors;
      de_cnt = 0;
      cnt = 0;
      wait_vsync_fall(1'b0, ok);
      if (ok) begin
         check_pixel(de_cnt);
         while (de_cnt < PIXELS && cnt < FRAME_TIMEOUT) begin
            if (de_cnt >= PIXELS / 2) begin
               enable_req = 1'b0;   // drop mid frame, the frame must still finish
            end
            step_cycle(1'b0);
            check_pixel(de_cnt);
            cnt++;
         end
         if (de_cnt < PIXELS) begin
            note_failure("de stopped before the end of the frame after enable fell");
         end
         for (cnt = 0; cnt < QUIET_CYCLES; cnt++) begin
            step_cycle(1'b0);
            check_value("de after stop", 0, int'(de));
         end
         check_value("load_ok after stop", 1, int'(load_ok));
         check_value("hsync after stop", 0, int'(hsync));
         check_value("vsync after stop", 0, int'(vsync));
         taken0 = writes_taken;
         for (i = 0; i < 256; i++) begin
            step_cycle(1'b1);
         end
         check_value("writes accepted after stop", 256, writes_taken - taken0);
         enable_req = 1'b1;
         check_frame(1'b0);
      end
      end_test("stop and restart", e0);

      $display("%0d tests, %0d with errors, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+hw
hw/video_pkg.sv
hw/scan_timing.sv
hw/color_plane_ram.sv
hw/display_ctrl.sv
hw/pixel_output.sv
hw/frame_display_top.sv
bench/tb_frame_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the frame display testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
   --top-module tb_frame_display \
   -o tb_frame_display \
   -f tb.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build returned status $status"
   exit 1
fi

output=$(./obj_dir/tb_frame_display)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation returned status $status"
   exit 1
fi

if echo "$output" | grep -q "^Testbench passed$"; then
   exit 0
fi
echo "pass message not found in simulation output"
exit 1
